// File: src/posit_pkg.sv
package posit_pkg;

   ////////////////////
   // Format widths
   ////////////////////

   localparam int POSIT_N   = 32;
   localparam int POSIT_ES  = 2;
   // log2 of the word width, sizes every run count
   localparam int POSIT_BS  = 5;
   // Signed regime count followed by the exponent
   localparam int SCALE_W   = POSIT_ES + POSIT_BS + 1;
   // Hidden bit plus the fraction left after the exponent
   localparam int FRAC_W    = POSIT_N - POSIT_ES + 1;

   // Regime fill, exponent and fraction before the regime shift
   localparam int PACK_W    = 2 * POSIT_N + 3;
   // Packed string plus room for the bits shifted out
   localparam int WIDE_W    = 3 * POSIT_N + 3;
   // From this regime shift on no fraction bit survives
   localparam int RND_LIMIT = POSIT_N - POSIT_ES - 2;

   ////////////////////
   // Stage types
   ////////////////////

   typedef logic [POSIT_N-1:0] posit_t;

   // One operand taken apart
   typedef struct packed {
      logic                rc;
      logic [POSIT_BS-1:0] regime;
      logic [POSIT_ES-1:0] exp;
      logic [FRAC_W-1:0]   frac;
   } posit_fields_t;

   // Input register stage
   typedef struct packed {
      logic   start;
      posit_t in_a;
      posit_t in_b;
   } operands_t;

   // Aligned sum, scale of the larger operand
   typedef struct packed {
      logic               sign;
      logic [SCALE_W-1:0] scale;
      logic [POSIT_N:0]   sum;
   } sum_t;

   // Leading one itself travels as has_one
   typedef struct packed {
      logic                sign;
      logic [POSIT_N-2:0]  frac;
      logic [POSIT_ES-1:0] exp;
      logic [POSIT_BS-1:0] rshift;
      logic                scale_neg;
      logic                has_one;
   } norm_t;

   typedef struct packed {
      posit_t word;
      logic   nar;
      logic   zero;
   } result_t;

endpackage

// File: src/posit_lod.sv
module posit_lod
   import posit_pkg::*;
(
   input  posit_t              in_i,
   output logic [POSIT_BS-1:0] count_o
);

   // Per level node valids and counts, level 0 is the single bits
   logic [POSIT_N-1:0]  vld [POSIT_BS+1];
   logic [POSIT_BS-1:0] cnt [POSIT_BS+1][POSIT_N];

   assign vld[0] = in_i;

   genvar lvl;
   genvar node;

   generate
      for (node = 0; node < POSIT_N; node++)
      begin : g_leaf
         assign cnt[0][node] = '0;
      end

      // Each node merges an upper and a lower half
      for (lvl = 1; lvl <= POSIT_BS; lvl++)
      begin : g_level
         for (node = 0; node < (POSIT_N >> lvl); node++)
         begin : g_node
            assign vld[lvl][node] = vld[lvl-1][2*node+1] | vld[lvl-1][2*node];
            // Upper half wins, else skip the whole upper half
            assign cnt[lvl][node] = vld[lvl-1][2*node+1] ? cnt[lvl-1][2*node+1] :
               (cnt[lvl-1][2*node] | (POSIT_BS'(vld[lvl-1][2*node]) << (lvl - 1)));
         end
      end
   endgenerate

   // All zero input reads as zero
   assign count_o = cnt[POSIT_BS][0];

endmodule

// File: src/posit_decode.sv
module posit_decode
   import posit_pkg::*;
(
   input  posit_t        mag_i,
   output posit_fields_t fields_o
);

   logic                rc;
   posit_t              run_word;
   logic [POSIT_BS-1:0] run_len;
   posit_t              body;
   logic                nonzero;

   ////////////////////
   // Regime run
   ////////////////////

   // Direction bit sits right below the sign
   assign rc = mag_i[POSIT_N-2];

   // Ones become zeros so a single LOD counts both kinds of run
   assign run_word = rc ? ~mag_i : mag_i;

   // Top bit is always zero here and counts as the first run bit
   // rc in the lsb stops a run of all ones
   posit_lod i_lod
   (
      .in_i    ({run_word[POSIT_N-2:0], rc}),
      .count_o (run_len)
   );

   assign fields_o.rc = rc;

   // A run of ones encodes one less than its length
   assign fields_o.regime = rc ? run_len - 1'b1 : run_len;

   ////////////////////
   // Exponent and fraction
   ////////////////////

   // Drop sign and first run bit, then the rest of the run and its stop bit
   assign body = {mag_i[POSIT_N-3:0], 2'b00} << run_len;

   assign fields_o.exp = body[POSIT_N-1 -: POSIT_ES];

   // Hidden one only for a nonzero word
   assign nonzero = |mag_i;

   assign fields_o.frac = {nonzero, body[POSIT_N-POSIT_ES-1:0]};

endmodule

// File: src/posit_align_add.sv
module posit_align_add
   import posit_pkg::*;
(
   input  posit_fields_t fields_a_i,
   input  posit_fields_t fields_b_i,
   input  logic          sign_a_i,
   input  logic          sign_b_i,
   input  posit_t        mag_a_i,
   input  posit_t        mag_b_i,
   output sum_t          sum_o
);

   logic                a_large;
   logic                add_op;
   posit_fields_t       f_l;
   posit_fields_t       f_s;
   logic [SCALE_W-1:0]  scale_l;
   logic [SCALE_W-1:0]  scale_s;
   logic [SCALE_W-1:0]  diff;
   logic [POSIT_BS-1:0] shift;
   posit_t              frac_l;
   posit_t              frac_s;
   posit_t              frac_s_sh;

   // Run length to signed regime count
   function automatic logic [POSIT_BS:0] signed_regime(input logic rc,
                                                       input logic [POSIT_BS-1:0] run);
      signed_regime = rc ? {1'b0, run} : -{1'b0, run};
   endfunction

   ////////////////////
   // Compare and swap
   ////////////////////

   // Magnitudes compare as plain integers
   assign a_large = mag_a_i[POSIT_N-2:0] >= mag_b_i[POSIT_N-2:0];

   // Same signs add, different signs subtract
   assign add_op = sign_a_i ~^ sign_b_i;

   assign f_l = a_large ? fields_a_i : fields_b_i;
   assign f_s = a_large ? fields_b_i : fields_a_i;

   ////////////////////
   // Scale difference
   ////////////////////

   assign scale_l = {signed_regime(f_l.rc, f_l.regime), f_l.exp};
   assign scale_s = {signed_regime(f_s.rc, f_s.regime), f_s.exp};

   // Never negative after the swap, fits unsigned
   assign diff = scale_l - scale_s;

   // Past the word width everything shifts out anyway
   assign shift = (|diff[SCALE_W-1:POSIT_BS]) ? '1 : diff[POSIT_BS-1:0];

   ////////////////////
   // Align and add
   ////////////////////

   assign frac_l = {f_l.frac, {POSIT_ES-1{1'b0}}};
   assign frac_s = {f_s.frac, {POSIT_ES-1{1'b0}}};

   // Barrel shift of the smaller fraction
   assign frac_s_sh = frac_s >> shift;

   assign sum_o.sign  = a_large ? sign_a_i : sign_b_i;
   assign sum_o.scale = scale_l;
   // One extra bit keeps the carry
   assign sum_o.sum   = add_op ? {1'b0, frac_l} + {1'b0, frac_s_sh} :
                                 {1'b0, frac_l} - {1'b0, frac_s_sh};

endmodule

// File: src/posit_normalize.sv
module posit_normalize
   import posit_pkg::*;
(
   input  sum_t  sum_i,
   output norm_t norm_o
);

   posit_t              lod_in;
   logic [POSIT_BS-1:0] lead;
   posit_t              shifted;
   posit_t              frac_n;
   logic [SCALE_W-1:0]  scale_r;
   logic [SCALE_W-1:0]  scale_abs;
   logic [POSIT_BS-1:0] run_base;

   ////////////////////
   // Leading one
   ////////////////////

   // Carry and top bit fold together, both need no left shift
   assign lod_in = {sum_i.sum[POSIT_N] | sum_i.sum[POSIT_N-1], sum_i.sum[POSIT_N-2:0]};

   posit_lod i_lod
   (
      .in_i    (lod_in),
      .count_o (lead)
   );

   assign shifted = sum_i.sum[POSIT_N:1] << lead;

   // No carry means the one still sits a place too low
   assign frac_n = shifted[POSIT_N-1] ? shifted : {shifted[POSIT_N-2:0], 1'b0};

   ////////////////////
   // Result scale
   ////////////////////

   assign scale_r = sum_i.scale - SCALE_W'(lead) + SCALE_W'(sum_i.sum[POSIT_N]);

   assign scale_abs = scale_r[SCALE_W-1] ? -scale_r : scale_r;
   assign run_base  = scale_abs[SCALE_W-2:POSIT_ES];

   // Exponent bits are the low scale bits for either sign
   assign norm_o.exp = scale_r[POSIT_ES-1:0];

   // Positive scale k needs k+1 ones
   // negative scale rounds its run up unless exactly divisible
   assign norm_o.rshift = (!scale_r[SCALE_W-1] || (|scale_abs[POSIT_ES-1:0])) ?
                          run_base + 1'b1 : run_base;

   assign norm_o.scale_neg = scale_r[SCALE_W-1];
   assign norm_o.sign      = sum_i.sign;
   assign norm_o.frac      = frac_n[POSIT_N-2:0];
   // Low when the difference cancelled to zero
   assign norm_o.has_one   = frac_n[POSIT_N-1];

endmodule

// File: src/posit_round_pack.sv
module posit_round_pack
   import posit_pkg::*;
(
   input  norm_t  norm_i,
   input  logic   nar_i,
   input  logic   zero_i,
   output posit_t word_o
);

   logic [PACK_W-1:0]  pack;
   logic [WIDE_W-1:0]  wide;
   posit_t             trunc;
   logic               lsb;
   logic               guard;
   logic               rnd;
   logic               sticky;
   logic               ulp;
   posit_t             rounded;
   logic [POSIT_N-2:0] mag;
   posit_t             signed_word;

   ////////////////////
   // Packing
   ////////////////////

   // Fill of the opposite run bit, stop bit, exponent, fraction
   assign pack = {{POSIT_N{~norm_i.scale_neg}}, norm_i.scale_neg, norm_i.exp,
                  norm_i.frac, {3-POSIT_ES{1'b0}}};

   // Fill slides down into the top as the regime run, low part keeps what falls out
   assign wide = {pack, {POSIT_N{1'b0}}} >> norm_i.rshift;

   // Magnitude bits on top, guard bit at the bottom
   assign trunc = wide[2*POSIT_N+2:POSIT_N+3];

   ////////////////////
   // Round half to even
   ////////////////////

   assign lsb    = wide[POSIT_N+4];
   assign guard  = wide[POSIT_N+3];
   assign rnd    = wide[POSIT_N+2];
   assign sticky = |wide[POSIT_N+1:0];

   // Up when above half, or exactly half with an odd lsb
   assign ulp = guard & (rnd | sticky | lsb);

   // Adding at the guard carries into the lsb since guard is set
   assign rounded = (norm_i.rshift < RND_LIMIT) ? trunc + POSIT_N'(ulp) : trunc;

   // Guard dropped here
   assign mag = rounded[POSIT_N-1:1];

   ////////////////////
   // Sign and specials
   ////////////////////

   assign signed_word = norm_i.sign ? -{1'b0, mag} : {1'b0, mag};

   // NaR is the top bit alone, zero and cancellation give all zeros
   assign word_o = (nar_i | zero_i | ~norm_i.has_one) ?
                   {nar_i, {POSIT_N-1{1'b0}}} : signed_word;

endmodule

// File: src/posit_sub_top.sv
module posit_sub_top
   import posit_pkg::*;
(
   input  logic   Clk,
   input  logic   rst,
   input  logic   start_i,
   input  posit_t in_a_i,
   input  posit_t in_b_i,
   output posit_t result_o,
   output logic   nar_o,
   output logic   zero_o,
   output logic   done_o
);

   operands_t     ops_q;
   result_t       res_d;
   result_t       res_q;
   logic          done_q;
   posit_t        op_a;
   posit_t        op_b;
   posit_t        mag_a;
   posit_t        mag_b;
   logic          tail_a;
   logic          tail_b;
   logic          nar;
   logic          zero;
   posit_fields_t fields_a;
   posit_fields_t fields_b;
   sum_t          sum;
   norm_t         norm;

   ////////////////////
   // Input stage
   ////////////////////

   always_ff @(posedge Clk)
   begin
      if (rst)
      begin
         ops_q <= '0;
      end
      else
      begin
         ops_q <= '{start: start_i, in_a: in_a_i, in_b: in_b_i};
      end
   end

   // a - b as a + (-b)
   assign op_a = ops_q.in_a;
   assign op_b = -ops_q.in_b;

   // Magnitudes for decode and compare
   assign mag_a = op_a[POSIT_N-1] ? -op_a : op_a;
   assign mag_b = op_b[POSIT_N-1] ? -op_b : op_b;

   // Special words have nothing below the sign
   assign tail_a = |op_a[POSIT_N-2:0];
   assign tail_b = |op_b[POSIT_N-2:0];

   assign nar  = (op_a[POSIT_N-1] & ~tail_a) | (op_b[POSIT_N-1] & ~tail_b);
   assign zero = ~(op_a[POSIT_N-1] | tail_a) & ~(op_b[POSIT_N-1] | tail_b);

   ////////////////////
   // Datapath
   ////////////////////

   posit_decode i_decode_a
   (
      .mag_i    (mag_a),
      .fields_o (fields_a)
   );

   posit_decode i_decode_b
   (
      .mag_i    (mag_b),
      .fields_o (fields_b)
   );

   posit_align_add i_align_add
   (
      .fields_a_i (fields_a),
      .fields_b_i (fields_b),
      .sign_a_i   (op_a[POSIT_N-1]),
      .sign_b_i   (op_b[POSIT_N-1]),
      .mag_a_i    (mag_a),
      .mag_b_i    (mag_b),
      .sum_o      (sum)
   );

   posit_normalize i_normalize
   (
      .sum_i  (sum),
      .norm_o (norm)
   );

   posit_round_pack i_round_pack
   (
      .norm_i (norm),
      .nar_i  (nar),
      .zero_i (zero),
      .word_o (res_d.word)
   );

   assign res_d.nar  = nar;
   assign res_d.zero = zero;

   ////////////////////
   // Output stage
   ////////////////////

   always_ff @(posedge Clk)
   begin
      if (rst)
      begin
         res_q  <= '0;
         done_q <= 1'b0;
      end
      else
      begin
         res_q  <= res_d;
         // Start rides along with its operands
         done_q <= ops_q.start;
      end
   end

   assign result_o = res_q.word;
   assign nar_o    = res_q.nar;
   assign zero_o   = res_q.zero;
   assign done_o   = done_q;

endmodule

// File: tests/tb_posit_sub.sv
module tb_posit_sub
   import posit_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 4;
   // Two edges from driving to done_o
   localparam int LATENCY      = 2;
   // Leading vectors sent with no gap at all
   localparam int BURST_LEN    = 4;
   localparam int LABEL_LEN    = 24;

   typedef struct packed {
      logic [8*LABEL_LEN-1:0] label;
      posit_t                 in_a;
      posit_t                 in_b;
      result_t                expected;
   } vector_t;

   logic    Clk;
   logic    rst;
   logic    start;
   posit_t  in_a;
   posit_t  in_b;
   posit_t  result_word;
   logic    nar_flag;
   logic    zero_flag;
   logic    done;

   vector_t vectors[$];
   // Vectors in flight with the cycle their done_o is due
   vector_t pending[$];
   int      due[$];
   int      cycle      = 0;
   int      err_count  = 0;
   int      pass_count = 0;
   int      fail_count = 0;
   logic    loaded     = 1'b0;

   posit_sub_top i_dut
   (
      .Clk      (Clk),
      .rst      (rst),
      .start_i  (start),
      .in_a_i   (in_a),
      .in_b_i   (in_b),
      .result_o (result_word),
      .nar_o    (nar_flag),
      .zero_o   (zero_flag),
      .done_o   (done)
   );

   ////////////////////
   // Clock and cycle count
   ////////////////////

   initial
   begin
      Clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) Clk = ~Clk;
      end
   end

   always @(posedge Clk)
   begin
      cycle <= cycle + 1;
   end

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("error at time %0t: %s expected %b actual %b", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_result(input result_t exp, input result_t act);
      if (act.word !== exp.word)
      begin
         $display("error at time %0t: result_o expected %h actual %h",
                  $time, exp.word, act.word);
         err_count++;
      end
      check_flag("nar_o", exp.nar, act.nar);
      check_flag("zero_o", exp.zero, act.zero);
   endtask

   ////////////////////
   // Vector file
   ////////////////////

   task automatic read_vectors();
      int                     fd;
      logic [1023:0]          header;
      logic [8*LABEL_LEN-1:0] label;
      posit_t                 a;
      posit_t                 b;
      posit_t                 w;
      logic                   nar_bit;
      logic                   zero_bit;
      vector_t                v;
      fd = $fopen("tests/posit_sub_tests.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the vector file tests/posit_sub_tests.txt");
         err_count++;
      end
      else
      begin
         // First line names the columns
         void'($fgets(header, fd));
         while ($fscanf(fd, "%s %h %h %h %b %b", label, a, b, w, nar_bit, zero_bit) == 6)
         begin
            v.label    = label;
            v.in_a     = a;
            v.in_b     = b;
            v.expected = '{word: w, nar: nar_bit, zero: zero_bit};
            vectors.push_back(v);
         end
         $fclose(fd);
         $display("read %0d vectors", vectors.size());
         if (vectors.size() == 0)
         begin
            $display("the vector file tests/posit_sub_tests.txt holds no vectors");
            err_count++;
         end
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   initial
   begin
      int gap;
      rst   = 1'b1;
      start = 1'b0;
      in_a  = '0;
      in_b  = '0;
      void'($urandom(86));
      read_vectors();
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge Clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      // Nothing may come out straight after reset
      @(negedge Clk);
      check_flag("done_o", 1'b0, done);
      @(posedge Clk);
      #DRIVE_DELAY;
      foreach (vectors[i])
      begin
         gap = (i < BURST_LEN) ? 0 : int'($urandom % 4);
         // Idle cycles with start low
         repeat (gap)
         begin
            @(posedge Clk);
            #DRIVE_DELAY;
         end
         start = 1'b1;
         in_a  = vectors[i].in_a;
         in_b  = vectors[i].in_b;
         pending.push_back(vectors[i]);
         due.push_back(cycle + LATENCY);
         @(posedge Clk);
         #DRIVE_DELAY;
         start = 1'b0;
      end
      while (pending.size() != 0)
      begin
         @(negedge Clk);
      end
      // A few quiet cycles catch a stray done_o
      repeat (4) @(negedge Clk);
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               vectors.size(), pass_count, fail_count, err_count);
      if (err_count == 0 && pass_count == vectors.size())
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   ////////////////////
   // Response monitor
   ////////////////////

   // Outputs settle well before the falling edge
   initial
   begin
      vector_t v;
      result_t act;
      int      due_cycle;
      int      errs_before;
      forever
      begin
         @(negedge Clk);
         if (!rst && done)
         begin
            if (pending.size() == 0)
            begin
               $display("done_o went high at time %0t with no vector in flight", $time);
               err_count++;
            end
            else
            begin
               v           = pending.pop_front();
               due_cycle   = due.pop_front();
               errs_before = err_count;
               if (cycle != due_cycle)
               begin
                  $display("result of %0s came at cycle %0d instead of cycle %0d",
                           v.label, cycle, due_cycle);
                  err_count++;
               end
               act.word = result_word;
               act.nar  = nar_flag;
               act.zero = zero_flag;
               check_result(v.expected, act);
               if (err_count == errs_before)
               begin
                  pass_count++;
                  $display("test %0s passed", v.label);
               end
               else
               begin
                  fail_count++;
                  $display("test %0s failed", v.label);
               end
            end
         end
         else if (!rst && pending.size() != 0 && due[0] <= cycle)
         begin
            // Result lost, done_o never came
            v         = pending.pop_front();
            due_cycle = due.pop_front();
            $display("test %0s failed, no done_o by cycle %0d", v.label, due_cycle);
            err_count++;
            fail_count++;
         end
      end
   end

   ////////////////////
   // Watchdog
   ////////////////////

   initial
   begin
      longint limit;
      wait (loaded);
      limit = longint'(vectors.size() + 20) * CLK_PERIOD * 4;
      #(limit);
      $display("timeout, the run did not finish in %0d time units", limit);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: tests/posit_sub_tests.txt
# label in_a in_b result nar zero (words in hex, flags as bits, result is in_a - in_b)
three_minus_one 4C000000 40000000 48000000 0 0
one_minus_three 40000000 4C000000 B8000000 0 0
one_minus_neg_one 40000000 C0000000 48000000 0 0
neg_one_minus_one C0000000 40000000 B8000000 0 0
two_minus_half 48000000 38000000 44000000 0 0
four_minus_half 50000000 38000000 4E000000 0 0
sixteen_minus_one 60000000 40000000 5F000000 0 0
half_minus_one 38000000 40000000 C8000000 0 0
neg3_minus_neg1 B4000000 C0000000 B8000000 0 0
one_minus_tiny 40000000 00800000 3FFFFFFF 0 0
tie_down_even 40000000 FF800000 40000000 0 0
tie_up_even 40000001 FF800000 40000002 0 0
above_half_up 40000000 FF700000 40000001 0 0
below_half_down 40000000 FF900000 40000000 0 0
neg_tie_even C0000000 00800000 C0000000 0 0
x_minus_x 4C000000 4C000000 00000000 0 0
zero_minus_zero 00000000 00000000 00000000 0 1
zero_minus_one 00000000 40000000 C0000000 0 0
two_minus_zero 48000000 00000000 48000000 0 0
nar_minus_one 80000000 40000000 80000000 1 0
one_minus_nar 40000000 80000000 80000000 1 0

// File: list.f
src/posit_pkg.sv
src/posit_lod.sv
src/posit_decode.sv
src/posit_align_add.sv
src/posit_normalize.sv
src/posit_round_pack.sv
src/posit_sub_top.sv
tests/tb_posit_sub.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_posit_sub
FILELIST  = list.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
